// ==== src/sss_pkg.sv ====
`default_nettype none

package sss_pkg;

    parameter int IQ_W         = 16;
    parameter int SC_DW        = 2 * IQ_W;            // Real part in the upper half
    parameter int SSB_SC       = 240;
    parameter int SSB_SYMBOLS  = 4;                   // PSS, PBCH, SSS and PBCH, PBCH
    parameter int SSS_SYMBOL   = 2;
    parameter int SSS_FIRST_SC = 56;
    parameter int SSS_LEN      = 127;
    parameter int PBCH_EDGE_SC = 48;

    parameter int N_ID_1_NUM = 336;
    parameter int N_ID_1_W   = 9;
    parameter int N_ID_W     = 10;                    // N_id tops out at 1007
    parameter int N_ID_2_W   = 2;
    parameter int SCORE_W    = 8;

    parameter int M_SEQ_ORDER = 7;                    // Register length of both generators

    // Bit i of the result holds x(i), with x(i+7) = x(i+tap) xor x(i)
    // and the standard initial state x(0) = 1, x(1..6) = 0
    function automatic logic [SSS_LEN-1:0] gen_m_seq(input int tap);
        logic [SSS_LEN-1:0] seq;
        seq    = '0;
        seq[0] = 1'b1;
        for (int i = 0; i < SSS_LEN - M_SEQ_ORDER; i++) begin
            seq[i + M_SEQ_ORDER] = seq[i + tap] ^ seq[i];
        end
        return seq;
    endfunction

    parameter logic [SSS_LEN-1:0] X0_SEQ = gen_m_seq(4);
    parameter logic [SSS_LEN-1:0] X1_SEQ = gen_m_seq(1);

endpackage

`default_nettype wire

// ==== src/ssb_grid_extractor.sv ====
`timescale 1ns/1ns
`default_nettype none

module ssb_grid_extractor import sss_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                pss_valid_i,
    input  wire logic [N_ID_2_W-1:0] n_id_2_i,
    input  wire logic [SC_DW-1:0]    s_axis_in_tdata_i,
    input  wire logic                s_axis_in_tvalid_i,
    input  wire logic                s_axis_in_tlast_i,
    input  wire logic                busy_i,
    output logic      [SC_DW-1:0]    m_axis_out_tdata_o,
    output logic                     m_axis_out_tvalid_o,
    output logic                     pbch_valid_o,
    output logic                     sss_valid_o,
    output logic                     sss_bit_o,
    output logic                     sss_bit_valid_o,
    output logic      [N_ID_2_W-1:0] n_id_2_o
);

    localparam int SC_W  = $clog2(SSB_SC);
    localparam int SYM_W = $clog2(SSB_SYMBOLS);

    logic                armed_q;
    logic                bits_en_q;
    logic [SYM_W-1:0]    sym_q;
    logic [SC_W-1:0]     sc_q;
    logic [N_ID_2_W-1:0] n_id_2_q;

    logic in_ssb;
    logic is_sss;
    logic is_pbch;
    logic edge_sc;

    assign in_ssb  = armed_q && s_axis_in_tvalid_i;
    assign edge_sc = (sc_q < PBCH_EDGE_SC) || (sc_q >= SSB_SC - PBCH_EDGE_SC);
    assign is_sss  = (sym_q == SYM_W'(SSS_SYMBOL)) && (sc_q >= SSS_FIRST_SC)
                     && (sc_q < SSS_FIRST_SC + SSS_LEN);
    // Symbols 1 and 3 carry PBCH across the whole band
    assign is_pbch = sym_q[0] || ((sym_q == SYM_W'(SSS_SYMBOL)) && edge_sc);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            armed_q   <= 1'b0;
            bits_en_q <= 1'b0;
            sym_q     <= '0;
            sc_q      <= '0;
        end else if (!armed_q) begin
            if (pss_valid_i) begin
                armed_q   <= 1'b1;
                bits_en_q <= !busy_i;                 // A running search keeps the flags only
                sym_q     <= '0;
                sc_q      <= '0;
            end
        end else if (s_axis_in_tvalid_i) begin
            if (s_axis_in_tlast_i) begin
                sc_q  <= '0;
                sym_q <= sym_q + 1'b1;
                if (sym_q == SYM_W'(SSB_SYMBOLS - 1)) begin
                    armed_q <= 1'b0;
                end
            end else begin
                sc_q <= sc_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!armed_q && pss_valid_i && !busy_i) begin
            n_id_2_q <= n_id_2_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_axis_out_tvalid_o <= 1'b0;
            pbch_valid_o        <= 1'b0;
            sss_valid_o         <= 1'b0;
            sss_bit_valid_o     <= 1'b0;
        end else begin
            m_axis_out_tvalid_o <= s_axis_in_tvalid_i;
            pbch_valid_o        <= in_ssb && is_pbch;
            sss_valid_o         <= in_ssb && is_sss;
            sss_bit_valid_o     <= in_ssb && is_sss && bits_en_q;
        end
    end

    always_ff @(posedge clk_i) begin
        m_axis_out_tdata_o <= s_axis_in_tdata_i;
        sss_bit_o          <= s_axis_in_tdata_i[SC_DW-1]; // Sign of the real part
    end

    assign n_id_2_o = n_id_2_q;

endmodule

`default_nettype wire

// ==== src/sss_correlator.sv ====
`timescale 1ns/1ns
`default_nettype none

module sss_correlator import sss_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                sss_bit_i,
    input  wire logic                sss_bit_valid_i,
    input  wire logic [N_ID_2_W-1:0] n_id_2_i,
    output logic                     busy_o,
    output logic      [SCORE_W-1:0]  score_o,
    output logic      [N_ID_1_W-1:0] score_n_id_1_o,
    output logic                     score_valid_o,
    output logic                     search_done_o,
    output logic      [N_ID_2_W-1:0] n_id_2_o
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_FILL   = 2'd1;
    localparam logic [1:0] ST_SEARCH = 2'd2;

    localparam int IDX_W  = $clog2(SSS_LEN);
    localparam int GRP_W  = 2;
    localparam int M1_MOD = 112;

    logic [1:0]          state_q;
    logic [IDX_W-1:0]    cnt_q;                       // Fill count, then subcarrier n
    logic [SSS_LEN-1:0]  sss_buf_q;
    logic [N_ID_2_W-1:0] n_id_2_q;
    logic [N_ID_1_W-1:0] id_q;
    logic [IDX_W-1:0]    m1_q;
    logic [GRP_W-1:0]    grp_q;                       // floor(N_id_1 / 112)
    logic [IDX_W-1:0]    idx0_q;
    logic [IDX_W-1:0]    idx1_q;
    logic [SCORE_W-1:0]  acc_q;

    logic             agree;
    logic             last_n;
    logic             last_id;
    logic             m1_wrap;
    logic [IDX_W-1:0] m1_next;
    logic [GRP_W-1:0] grp_next;
    logic [IDX_W-1:0] m0_next;
    logic [IDX_W-1:0] m0_first;

    function automatic logic [IDX_W-1:0] wrap_inc(input logic [IDX_W-1:0] v);
        return (v == IDX_W'(SSS_LEN - 1)) ? '0 : v + 1'b1;
    endfunction

    assign agree    = sss_buf_q[cnt_q] == (X0_SEQ[idx0_q] ^ X1_SEQ[idx1_q]);
    assign last_n   = cnt_q == IDX_W'(SSS_LEN - 1);
    assign last_id  = id_q == N_ID_1_W'(N_ID_1_NUM - 1);
    assign m1_wrap  = m1_q == IDX_W'(M1_MOD - 1);
    assign m1_next  = m1_wrap ? '0 : m1_q + 1'b1;
    assign grp_next = m1_wrap ? grp_q + 1'b1 : grp_q;
    // m0 = 15 * floor(N_id_1 / 112) + 5 * N_id_2 stays below 127
    assign m0_next  = IDX_W'(15) * IDX_W'(grp_next) + IDX_W'(5) * IDX_W'(n_id_2_q);
    assign m0_first = IDX_W'(5) * IDX_W'(n_id_2_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= ST_IDLE;
            cnt_q         <= '0;
            id_q          <= '0;
            m1_q          <= '0;
            grp_q         <= '0;
            idx0_q        <= '0;
            idx1_q        <= '0;
            acc_q         <= '0;
            score_valid_o <= 1'b0;
            search_done_o <= 1'b0;
        end else begin
            score_valid_o <= 1'b0;
            search_done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (sss_bit_valid_i) begin
                        state_q <= ST_FILL;
                        cnt_q   <= IDX_W'(1);
                    end
                end
                ST_FILL: begin
                    if (sss_bit_valid_i) begin
                        if (last_n) begin
                            state_q <= ST_SEARCH;
                            cnt_q   <= '0;
                            id_q    <= '0;
                            m1_q    <= '0;
                            grp_q   <= '0;
                            idx0_q  <= m0_first;
                            idx1_q  <= '0;
                            acc_q   <= '0;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                ST_SEARCH: begin
                    if (last_n) begin
                        cnt_q         <= '0;
                        acc_q         <= '0;
                        id_q          <= id_q + 1'b1;
                        m1_q          <= m1_next;
                        grp_q         <= grp_next;
                        idx0_q        <= m0_next;
                        idx1_q        <= m1_next;
                        score_valid_o <= 1'b1;
                        search_done_o <= last_id;
                        if (last_id) begin
                            state_q <= ST_IDLE;
                        end
                    end else begin
                        cnt_q  <= cnt_q + 1'b1;
                        acc_q  <= acc_q + SCORE_W'(agree);
                        idx0_q <= wrap_inc(idx0_q);
                        idx1_q <= wrap_inc(idx1_q);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sss_bit_valid_i && (state_q != ST_SEARCH)) begin
            sss_buf_q <= {sss_bit_i, sss_buf_q[SSS_LEN-1:1]}; // First bit ends at index 0
        end
        if ((state_q == ST_FILL) && sss_bit_valid_i && last_n) begin
            n_id_2_q <= n_id_2_i;
        end
        if ((state_q == ST_SEARCH) && last_n) begin
            score_o        <= acc_q + SCORE_W'(agree);
            score_n_id_1_o <= id_q;
        end
    end

    assign busy_o   = state_q != ST_IDLE;
    assign n_id_2_o = n_id_2_q;

endmodule

`default_nettype wire

// ==== src/sss_peak_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module sss_peak_select import sss_pkg::*; #(
    parameter int unsigned DETECT_THRESHOLD = 100
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic [SCORE_W-1:0]  score_i,
    input  wire logic [N_ID_1_W-1:0] score_n_id_1_i,
    input  wire logic                score_valid_i,
    input  wire logic                search_done_i,
    input  wire logic [N_ID_2_W-1:0] n_id_2_i,
    output logic      [N_ID_1_W-1:0] m_axis_sss_tdata_o,
    output logic                     m_axis_sss_tvalid_o,
    output logic      [N_ID_W-1:0]   n_id_o,
    output logic                     sss_miss_o
);

    logic [SCORE_W-1:0]  best_q;
    logic [N_ID_1_W-1:0] best_id_q;

    logic                take_new;
    logic [SCORE_W-1:0]  final_score;
    logic [N_ID_1_W-1:0] final_id;

    // Strictly greater, so the lowest N_id_1 keeps a tie
    assign take_new    = score_valid_i && (score_i > best_q);
    assign final_score = take_new ? score_i : best_q;
    assign final_id    = take_new ? score_n_id_1_i : best_id_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            best_q              <= '0;
            best_id_q           <= '0;
            m_axis_sss_tvalid_o <= 1'b0;
            sss_miss_o          <= 1'b0;
        end else begin
            m_axis_sss_tvalid_o <= 1'b0;
            sss_miss_o          <= 1'b0;
            if (search_done_i) begin
                best_q              <= '0;
                best_id_q           <= '0;
                m_axis_sss_tvalid_o <= final_score >= DETECT_THRESHOLD;
                sss_miss_o          <= final_score < DETECT_THRESHOLD;
            end else if (take_new) begin
                best_q    <= score_i;
                best_id_q <= score_n_id_1_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (search_done_i) begin
            m_axis_sss_tdata_o <= final_id;
            n_id_o             <= N_ID_W'(final_id) * N_ID_W'(3) + N_ID_W'(n_id_2_i);
        end
    end

endmodule

`default_nettype wire

// ==== src/cell_id_search.sv ====
`timescale 1ns/1ns
`default_nettype none

module cell_id_search import sss_pkg::*; #(
    parameter int unsigned DETECT_THRESHOLD = 100
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                pss_valid_i,
    input  wire logic [N_ID_2_W-1:0] n_id_2_i,
    input  wire logic [SC_DW-1:0]    s_axis_in_tdata_i,
    input  wire logic                s_axis_in_tvalid_i,
    input  wire logic                s_axis_in_tlast_i,
    output logic      [SC_DW-1:0]    m_axis_out_tdata_o,
    output logic                     m_axis_out_tvalid_o,
    output logic                     pbch_valid_o,
    output logic                     sss_valid_o,
    output logic      [N_ID_1_W-1:0] m_axis_sss_tdata_o,
    output logic                     m_axis_sss_tvalid_o,
    output logic      [N_ID_W-1:0]   n_id_o,
    output logic                     sss_miss_o
);

    logic                sss_bit;
    logic                sss_bit_valid;
    logic [N_ID_2_W-1:0] n_id_2;
    logic                busy;
    logic [SCORE_W-1:0]  score;
    logic [N_ID_1_W-1:0] score_n_id_1;
    logic                score_valid;
    logic                search_done;
    logic [N_ID_2_W-1:0] n_id_2_q;

    ssb_grid_extractor ssb_grid_extractor_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .pss_valid_i         (pss_valid_i),
        .n_id_2_i            (n_id_2_i),
        .s_axis_in_tdata_i   (s_axis_in_tdata_i),
        .s_axis_in_tvalid_i  (s_axis_in_tvalid_i),
        .s_axis_in_tlast_i   (s_axis_in_tlast_i),
        .busy_i              (busy),
        .m_axis_out_tdata_o  (m_axis_out_tdata_o),
        .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
        .pbch_valid_o        (pbch_valid_o),
        .sss_valid_o         (sss_valid_o),
        .sss_bit_o           (sss_bit),
        .sss_bit_valid_o     (sss_bit_valid),
        .n_id_2_o            (n_id_2)
    );

    sss_correlator sss_correlator_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .sss_bit_i       (sss_bit),
        .sss_bit_valid_i (sss_bit_valid),
        .n_id_2_i        (n_id_2),
        .busy_o          (busy),
        .score_o         (score),
        .score_n_id_1_o  (score_n_id_1),
        .score_valid_o   (score_valid),
        .search_done_o   (search_done),
        .n_id_2_o        (n_id_2_q)
    );

    sss_peak_select #(
        .DETECT_THRESHOLD (DETECT_THRESHOLD)
    ) sss_peak_select_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .score_i             (score),
        .score_n_id_1_i      (score_n_id_1),
        .score_valid_i       (score_valid),
        .search_done_i       (search_done),
        .n_id_2_i            (n_id_2_q),
        .m_axis_sss_tdata_o  (m_axis_sss_tdata_o),
        .m_axis_sss_tvalid_o (m_axis_sss_tvalid_o),
        .n_id_o              (n_id_o),
        .sss_miss_o          (sss_miss_o)
    );

endmodule

`default_nettype wire

// ==== testbench/cell_id_search_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module cell_id_search_checker import sss_pkg::*; (
    input wire logic              clk_i,
    input wire logic              rst_n_i,
    input wire logic              result_valid_i,
    input wire logic              result_miss_i,
    input wire logic [N_ID_W-1:0] n_id_i,
    input wire logic              grid_valid_i,
    input wire logic              pbch_valid_i,
    input wire logic              sss_valid_i
);

    result_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(result_valid_i && result_miss_i))
        else $error("Detection and miss strobes are high together");

    // N_id = 3 * N_id_1 + N_id_2 never reaches 3 * 336
    n_id_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i |-> (n_id_i < N_ID_W'(3 * N_ID_1_NUM)))
        else $error("N_id out of range with the detection strobe");

    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(pbch_valid_i && sss_valid_i))
        else $error("PBCH and SSS flags are high together");

    flags_need_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pbch_valid_i || sss_valid_i) |-> grid_valid_i)
        else $error("A grid flag is high without a valid element");

endmodule

bind cell_id_search cell_id_search_checker checker_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .result_valid_i (m_axis_sss_tvalid_o),
    .result_miss_i  (sss_miss_o),
    .n_id_i         (n_id_o),
    .grid_valid_i   (m_axis_out_tvalid_o),
    .pbch_valid_i   (pbch_valid_o),
    .sss_valid_i    (sss_valid_o)
);

`default_nettype wire

// ==== testbench/cell_id_search_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cell_id_search_tb import sss_pkg::*; ();

    localparam int unsigned DETECT_THRESHOLD = 100;
    localparam int NUM_SSB        = 6;                      // Four cells, one noise SSS, one ignored
    localparam int SEARCH_CYCLES  = N_ID_1_NUM * SSS_LEN;
    localparam int SSB_MAX_CYCLES = 2 * SSB_SYMBOLS * SSB_SC; // At most one gap per element
    localparam int TIMEOUT_CYCLES = NUM_SSB * (SEARCH_CYCLES + SSB_MAX_CYCLES) + 10000;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                pss_valid;
    logic [N_ID_2_W-1:0] n_id_2;
    logic [SC_DW-1:0]    s_axis_in_tdata;
    logic                s_axis_in_tvalid;
    logic                s_axis_in_tlast;
    logic [SC_DW-1:0]    m_axis_out_tdata;
    logic                m_axis_out_tvalid;
    logic                pbch_valid;
    logic                sss_valid;
    logic [N_ID_1_W-1:0] m_axis_sss_tdata;
    logic                m_axis_sss_tvalid;
    logic [N_ID_W-1:0]   n_id;
    logic                sss_miss;

    integer seed = 32'hcebe5ff9;
    int     cycle_cnt = 0;
    int     results_seen = 0;
    int     results_expected = 0;

    logic                prev_valid = 1'b0;             // What the last driven cycle should produce
    logic [SC_DW-1:0]    prev_data = '0;
    logic                prev_pbch = 1'b0;
    logic                prev_sss = 1'b0;

    logic                exp_detect_q[$];
    logic [N_ID_1_W-1:0] exp_id_q[$];
    logic [N_ID_W-1:0]   exp_nid_q[$];
    logic                exp_detect;
    logic [N_ID_1_W-1:0] exp_id;
    logic [N_ID_W-1:0]   exp_nid;

    cell_id_search #(
        .DETECT_THRESHOLD (DETECT_THRESHOLD)
    ) uut (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .pss_valid_i         (pss_valid),
        .n_id_2_i            (n_id_2),
        .s_axis_in_tdata_i   (s_axis_in_tdata),
        .s_axis_in_tvalid_i  (s_axis_in_tvalid),
        .s_axis_in_tlast_i   (s_axis_in_tlast),
        .m_axis_out_tdata_o  (m_axis_out_tdata),
        .m_axis_out_tvalid_o (m_axis_out_tvalid),
        .pbch_valid_o        (pbch_valid),
        .sss_valid_o         (sss_valid),
        .m_axis_sss_tdata_o  (m_axis_sss_tdata),
        .m_axis_sss_tvalid_o (m_axis_sss_tvalid),
        .n_id_o              (n_id),
        .sss_miss_o          (sss_miss)
    );

    always #20 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                                   cycle_cnt, results_seen, results_expected));
        end
    end

    task automatic check_sc(input logic got_valid, input logic [SC_DW-1:0] got_data,
                            input logic got_pbch, input logic got_sss,
                            input logic want_valid, input logic [SC_DW-1:0] want_data,
                            input logic want_pbch, input logic want_sss);
        if (got_valid !== want_valid) begin
            report_error($sformatf("Mismatch at %0t ns: m_axis_out_tvalid_o got %b expected %b",
                                   $time, got_valid, want_valid));
        end else if (want_valid && (got_data !== want_data)) begin
            report_error($sformatf("Mismatch at %0t ns: m_axis_out_tdata_o got %h expected %h",
                                   $time, got_data, want_data));
        end else if (got_pbch !== want_pbch) begin
            report_error($sformatf("Mismatch at %0t ns: pbch_valid_o got %b expected %b",
                                   $time, got_pbch, want_pbch));
        end else if (got_sss !== want_sss) begin
            report_error($sformatf("Mismatch at %0t ns: sss_valid_o got %b expected %b",
                                   $time, got_sss, want_sss));
        end
    endtask

    task automatic check_n_id_1(input logic [N_ID_1_W-1:0] got, input logic [N_ID_1_W-1:0] want);
        if (got !== want) begin
            report_error($sformatf("Mismatch at %0t ns: m_axis_sss_tdata_o got %0d expected %0d",
                                   $time, got, want));
        end
    endtask

    task automatic check_n_id(input logic [N_ID_W-1:0] got, input logic [N_ID_W-1:0] want);
        if (got !== want) begin
            report_error($sformatf("Mismatch at %0t ns: n_id_o got %0d expected %0d",
                                   $time, got, want));
        end
    endtask

    // Shift register view of x(i+7) = x(i+tap) xor x(i), started from x(0) = 1
    function automatic logic [SSS_LEN-1:0] m_sequence(input int tap);
        logic [6:0]         state;
        logic [SSS_LEN-1:0] seq;
        state = 7'b0000001;
        for (int i = 0; i < SSS_LEN; i++) begin
            seq[i] = state[0];
            state  = {state[tap] ^ state[0], state[6:1]};
        end
        return seq;
    endfunction

    function automatic logic [N_ID_1_W-1:0] best_hypothesis(input logic [SSS_LEN-1:0] bits,
                                                            input int cell_n_id_2,
                                                            output int peak);
        logic [SSS_LEN-1:0]  x0;
        logic [SSS_LEN-1:0]  x1;
        logic [N_ID_1_W-1:0] best;
        int                  score;
        x0   = m_sequence(4);
        x1   = m_sequence(1);
        best = '0;
        peak = -1;
        for (int id = 0; id < N_ID_1_NUM; id++) begin
            score = 0;
            for (int n = 0; n < SSS_LEN; n++) begin
                if (bits[n] == (x0[(n + 15 * (id / 112) + 5 * cell_n_id_2) % SSS_LEN]
                                ^ x1[(n + id % 112) % SSS_LEN])) begin
                    score++;
                end
            end
            if (score > peak) begin                    // Lowest N_id_1 keeps a tie
                peak = score;
                best = N_ID_1_W'(id);
            end
        end
        return best;
    endfunction

    task automatic step(input logic valid, input logic [SC_DW-1:0] data, input logic last,
                        input logic pbch, input logic sss, input logic pss);
        @(negedge clk);
        check_sc(m_axis_out_tvalid, m_axis_out_tdata, pbch_valid, sss_valid,
                 prev_valid, prev_data, prev_pbch, prev_sss);
        s_axis_in_tvalid = valid;
        s_axis_in_tdata  = data;
        s_axis_in_tlast  = last;
        pss_valid        = pss;
        prev_valid       = valid;
        prev_data        = data;
        prev_pbch        = pbch;
        prev_sss         = sss;
    endtask

    task automatic send_loose(input int count);
        for (int i = 0; i < count; i++) begin
            step(1'b1, $random(seed), (i % 7) == 6, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic send_ssb(input logic [N_ID_1_W-1:0] cell_n_id_1,
                            input logic [N_ID_2_W-1:0] cell_n_id_2,
                            input logic noise_sss, input logic accepted);
        logic [SSS_LEN-1:0]  x0;
        logic [SSS_LEN-1:0]  x1;
        logic [SSS_LEN-1:0]  sent;
        logic [SC_DW-1:0]    data;
        logic [N_ID_1_W-1:0] best;
        logic                sss_bit;
        logic                pbch;
        logic                sss;
        int                  m0;
        int                  m1;
        int                  re;
        int                  peak;
        x0     = m_sequence(4);
        x1     = m_sequence(1);
        sent   = '0;
        m0     = 15 * (int'(cell_n_id_1) / 112) + 5 * int'(cell_n_id_2);
        m1     = int'(cell_n_id_1) % 112;
        n_id_2 = cell_n_id_2;
        step(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
        for (int sym = 0; sym < SSB_SYMBOLS; sym++) begin
            for (int sc = 0; sc < SSB_SC; sc++) begin
                if (($random(seed) & 3) == 0) begin
                    step(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
                end
                data = $random(seed);
                sss  = (sym == SSS_SYMBOL) && (sc >= SSS_FIRST_SC)
                       && (sc < SSS_FIRST_SC + SSS_LEN);
                pbch = (sym == 1) || (sym == 3) || ((sym == SSS_SYMBOL)
                       && ((sc < PBCH_EDGE_SC) || (sc >= SSB_SC - PBCH_EDGE_SC)));
                if (sss) begin
                    if (noise_sss) begin
                        sss_bit = ($random(seed) & 1) != 0;
                    end else begin
                        sss_bit = x0[(sc - SSS_FIRST_SC + m0) % SSS_LEN]
                                  ^ x1[(sc - SSS_FIRST_SC + m1) % SSS_LEN];
                    end
                    re = (sss_bit ? -8000 : 8000) + $random(seed) % 1001;
                    data[SC_DW-1:IQ_W]      = re[IQ_W-1:0];
                    sent[sc - SSS_FIRST_SC] = re < 0;        // Hard bit is the sign
                end
                step(1'b1, data, sc == SSB_SC - 1, pbch, sss, 1'b0);
            end
        end
        if (accepted) begin
            best = best_hypothesis(sent, int'(cell_n_id_2), peak);
            if (noise_sss && (peak >= DETECT_THRESHOLD)) begin
                report_error("Noise SSS stimulus correlates at or above the detection threshold");
            end
            exp_detect_q.push_back(peak >= DETECT_THRESHOLD);
            exp_id_q.push_back(best);
            exp_nid_q.push_back(N_ID_W'(3 * int'(best) + int'(cell_n_id_2)));
            results_expected++;
        end
    endtask

    task automatic wait_results(input int count);
        while (results_seen < count) begin
            step(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && (m_axis_sss_tvalid || sss_miss)) begin
            if (m_axis_sss_tvalid && sss_miss) begin
                report_error("Detection and miss strobes are high in the same cycle");
            end else if (exp_detect_q.size() == 0) begin
                report_error("A search result arrived without an accepted SSB");
            end else begin
                exp_detect = exp_detect_q.pop_front();
                exp_id     = exp_id_q.pop_front();
                exp_nid    = exp_nid_q.pop_front();
                if (exp_detect !== m_axis_sss_tvalid) begin
                    report_error($sformatf(
                        "Mismatch at %0t ns: m_axis_sss_tvalid_o got %b expected %b",
                        $time, m_axis_sss_tvalid, exp_detect));
                end else if (exp_detect) begin
                    check_n_id_1(m_axis_sss_tdata, exp_id);
                    check_n_id(n_id, exp_nid);
                end
                results_seen++;
            end
        end
    end

    initial begin
        logic [N_ID_1_W-1:0] cell_id;
        logic [N_ID_2_W-1:0] cell_pss;
        rst_n            = 1'b0;
        pss_valid        = 1'b0;
        n_id_2           = '0;
        s_axis_in_tdata  = '0;
        s_axis_in_tvalid = 1'b0;
        s_axis_in_tlast  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        send_loose(40);                                // No PSS yet, so no flags
        for (int i = 0; i < 4; i++) begin
            cell_id  = N_ID_1_W'({$random(seed)} % N_ID_1_NUM);
            cell_pss = N_ID_2_W'({$random(seed)} % 3);
            send_ssb(cell_id, cell_pss, 1'b0, 1'b1);
            if (i == 2) begin
                // Arrives while the search runs and must not start another one
                send_ssb(N_ID_1_W'({$random(seed)} % N_ID_1_NUM), 2'd1, 1'b0, 1'b0);
            end
            wait_results(results_expected);
            send_loose(20);
        end
        send_ssb('0, N_ID_2_W'({$random(seed)} % 3), 1'b1, 1'b1);
        wait_results(results_expected);
        send_loose(20);
        if ((results_seen != results_expected) || (exp_detect_q.size() != 0)) begin
            report_error($sformatf("Expected %0d search results but saw %0d",
                                   results_expected, results_seen));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/sss_pkg.sv
src/ssb_grid_extractor.sv
src/sss_correlator.sv
src/sss_peak_select.sv
src/cell_id_search.sv
testbench/cell_id_search_checker.sv
testbench/cell_id_search_tb.sv

// ==== Makefile ====
# Verilator build and run of the cell ID search testbench

VERILATOR ?= verilator
TOP       ?= cell_id_search_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
